/* Makefile */
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= tb_mem_wr_top
FLIST     ?= mem_wr.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/beat_lane_counter.sv */
`timescale 1ns/1ps

module beat_lane_counter #(
  parameter int AXI_DW = 32
) (
  input  logic                         mem_top,
  input  logic                         axi_rstn_i,
  input  logic                         beat_load_i,
  input  logic                         aw_load_i,
  input  logic [mem_wr_pkg::LEN_W-1:0] len_i,
  lane_step_if.cnt                     ls
);
  import mem_wr_pkg::*;

  localparam int SW     = AXI_DW / 8;
  localparam int LANE_W = $clog2(SW);

  logic [LANE_W-1:0] lane_q;
  logic [LEN_W-1:0]  beat_q;

  always_ff @(posedge mem_top) begin
    if (axi_rstn_i) begin
      lane_q <= '0;
    end else if (beat_load_i) begin
      lane_q <= '0;
    end else if (ls.step) begin
      lane_q <= lane_q + 1'b1; // wraps to 0 after the top lane.
    end
  end

  always_ff @(posedge mem_top) begin
    if (axi_rstn_i) begin
      beat_q <= '0;
    end else if (aw_load_i) begin
      beat_q <= '0;
    end else if (ls.step && ls.lane_last) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  assign ls.lane_idx  = lane_q;
  assign ls.beat_idx  = beat_q;
  assign ls.lane_last = (lane_q == LANE_W'(SW - 1));
  assign ls.beat_last = (beat_q == len_i);

  // no lane is consumed past the last beat.
  a_beat_range: assert property (
    @(posedge mem_top) disable iff (axi_rstn_i)
    ls.step |-> (ls.beat_idx <= len_i)
  );

endmodule

/* hdl/burst_addr_gen.sv */
`timescale 1ns/1ps

module burst_addr_gen #(
  parameter int AXI_DW = 32,
  parameter int AXI_AW = 16
) (
  input  logic                         mem_top,
  input  logic                         axi_rstn_i,
  input  logic                         aw_load_i,
  input  logic [AXI_AW-1:0]            axi_awaddr_i,
  input  logic [mem_wr_pkg::LEN_W-1:0] axi_awlen_i,
  input  mem_wr_pkg::axi_burst_e       axi_awburst_i,
  lane_step_if.dat                     ls,
  output logic [AXI_AW-1:0]            addr_o,
  output logic [mem_wr_pkg::LEN_W-1:0] len_o
);
  import mem_wr_pkg::*;

  localparam int SW     = AXI_DW / 8;
  localparam int LANE_W = $clog2(SW);

  logic [AXI_AW-1:0] start_q;
  logic [LEN_W-1:0]  len_q;
  axi_burst_e        burst_q;

  logic [AXI_AW-1:0] beat_off;
  logic [AXI_AW-1:0] incr_addr;
  logic [AXI_AW-1:0] wrap_mask;
  logic [AXI_AW-1:0] beat_addr;

  always_ff @(posedge mem_top) begin
    if (aw_load_i) begin
      start_q <= {axi_awaddr_i[AXI_AW-1:LANE_W], {LANE_W{1'b0}}}; // aligned down.
    end
  end

  always_ff @(posedge mem_top) begin
    if (axi_rstn_i) begin
      len_q   <= '0;
      burst_q <= BURST_INCR;
    end else if (aw_load_i) begin
      len_q   <= axi_awlen_i;
      burst_q <= axi_awburst_i;
    end
  end

  assign beat_off  = AXI_AW'({ls.beat_idx, {LANE_W{1'b0}}});
  assign incr_addr = start_q + beat_off;
  // block of (len+1)*SW bytes, len+1 a power of two.
  assign wrap_mask = AXI_AW'({len_q, {LANE_W{1'b1}}});

  always_comb begin
    case (burst_q)
      BURST_FIXED: beat_addr = start_q;
      BURST_WRAP:  beat_addr = (start_q & ~wrap_mask) | (incr_addr & wrap_mask);
      default:     beat_addr = incr_addr;
    endcase
  end

  assign addr_o = beat_addr + AXI_AW'(ls.lane_idx);
  assign len_o  = len_q;

  a_wrap_len: assert property (
    @(posedge mem_top) disable iff (axi_rstn_i)
    (aw_load_i && axi_awburst_i == BURST_WRAP) |-> (axi_awlen_i inside {1, 3, 7, 15})
  );

endmodule

/* hdl/lane_step_if.sv */
`timescale 1ns/1ps

interface lane_step_if #(
  parameter int AXI_DW = 32
);
  import mem_wr_pkg::*;

  localparam int SW     = AXI_DW / 8;
  localparam int LANE_W = $clog2(SW);

  logic [LANE_W-1:0] lane_idx;  // byte lane within the beat.
  logic [LEN_W-1:0]  beat_idx;  // beat within the burst.
  logic              lane_last;
  logic              beat_last;
  logic              step;      // one lane consumed.

  modport cnt (
    output lane_idx, beat_idx, lane_last, beat_last,
    input  step
  );

  modport ctl (
    output step,
    input  lane_idx, beat_idx, lane_last, beat_last
  );

  modport dat (
    input lane_idx, beat_idx, lane_last, beat_last, step
  );

endinterface

/* hdl/mem_wr_pkg.sv */
package mem_wr_pkg;

  // axi burst type, 2'b11 is reserved.
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  // axi3 burst length field, beats = len + 1.
  localparam int LEN_W = 4;

  // system side is one byte wide.
  localparam int BYTE_W = 8;

  // smallest supported data bus.
  localparam int MIN_DW = 16;

endpackage

/* hdl/mem_wr_top.sv */
`timescale 1ns/1ps

module mem_wr_top #(
  parameter int AXI_DW = 32,
  parameter int AXI_AW = 16,
  parameter int AXI_IW = 4
) (
  input  logic                          mem_top,
  input  logic                          axi_rstn_i,
  input  logic [AXI_IW-1:0]             axi_awid_i,
  input  logic [AXI_AW-1:0]             axi_awaddr_i,
  input  logic [mem_wr_pkg::LEN_W-1:0]  axi_awlen_i,
  input  mem_wr_pkg::axi_burst_e        axi_awburst_i,
  input  logic                          axi_awvalid_i,
  output logic                          axi_awready_o,
  input  logic [AXI_IW-1:0]             axi_wid_i,
  input  logic [AXI_DW-1:0]             axi_wdata_i,
  input  logic [AXI_DW/8-1:0]           axi_wstrb_i,
  input  logic                          axi_wlast_i,
  input  logic                          axi_wvalid_i,
  output logic                          axi_wready_o,
  output logic                          sys_wen_o,
  output logic [AXI_AW-1:0]             sys_addr_o,
  output logic [mem_wr_pkg::BYTE_W-1:0] sys_wdata_o
);
  import mem_wr_pkg::*;

  if ((AXI_DW < MIN_DW) || ((AXI_DW & (AXI_DW - 1)) != 0)) begin : g_dw_check
    $error("AXI_DW must be a power of two of at least %0d", MIN_DW);
  end

  logic             aw_load;
  logic             beat_load;
  logic [LEN_W-1:0] len;
  logic [AXI_IW-1:0] awid_q; // only for the wid check.

  lane_step_if #(.AXI_DW(AXI_DW)) u_ls ();

  wr_burst_fsm u_fsm (
    .mem_top(mem_top), .axi_rstn_i(axi_rstn_i),
    .axi_awvalid_i(axi_awvalid_i), .axi_wvalid_i(axi_wvalid_i),
    .axi_wlast_i(axi_wlast_i), .axi_awready_o(axi_awready_o),
    .axi_wready_o(axi_wready_o), .aw_load_o(aw_load),
    .beat_load_o(beat_load), .ls(u_ls.ctl)
  );

  beat_lane_counter #(.AXI_DW(AXI_DW)) u_cnt (
    .mem_top(mem_top), .axi_rstn_i(axi_rstn_i), .beat_load_i(beat_load),
    .aw_load_i(aw_load), .len_i(len), .ls(u_ls.cnt)
  );

  wdata_beat_buffer #(.AXI_DW(AXI_DW)) u_buf (
    .mem_top(mem_top), .axi_rstn_i(axi_rstn_i), .beat_load_i(beat_load),
    .axi_wdata_i(axi_wdata_i), .axi_wstrb_i(axi_wstrb_i), .ls(u_ls.dat),
    .byte_o(sys_wdata_o), .byte_en_o(sys_wen_o)
  );

  burst_addr_gen #(.AXI_DW(AXI_DW), .AXI_AW(AXI_AW)) u_addr (
    .mem_top(mem_top), .axi_rstn_i(axi_rstn_i), .aw_load_i(aw_load),
    .axi_awaddr_i(axi_awaddr_i), .axi_awlen_i(axi_awlen_i),
    .axi_awburst_i(axi_awburst_i), .ls(u_ls.dat),
    .addr_o(sys_addr_o), .len_o(len)
  );

  always_ff @(posedge mem_top) begin
    if (aw_load) begin
      awid_q <= axi_awid_i;
    end
  end

  // no interleaving, every beat belongs to the open burst.
  a_wid_match: assert property (
    @(posedge mem_top) disable iff (axi_rstn_i)
    beat_load |-> (axi_wid_i == awid_q)
  );

endmodule

/* hdl/wdata_beat_buffer.sv */
`timescale 1ns/1ps

module wdata_beat_buffer #(
  parameter int AXI_DW = 32
) (
  input  logic                          mem_top,
  input  logic                          axi_rstn_i,
  input  logic                          beat_load_i,
  input  logic [AXI_DW-1:0]             axi_wdata_i,
  input  logic [AXI_DW/8-1:0]           axi_wstrb_i,
  lane_step_if.dat                      ls,
  output logic [mem_wr_pkg::BYTE_W-1:0] byte_o,
  output logic                          byte_en_o
);
  import mem_wr_pkg::*;

  localparam int SW = AXI_DW / 8;

  // one beat, seen whole on load and per lane on drain.
  typedef union packed {
    logic [AXI_DW-1:0]          word;
    logic [SW-1:0][BYTE_W-1:0]  lane;
  } beat_u;

  beat_u          beat_q;
  logic [SW-1:0]  strb_q;

  always_ff @(posedge mem_top) begin
    if (beat_load_i) begin
      beat_q.word <= axi_wdata_i;
    end
  end

  always_ff @(posedge mem_top) begin
    if (axi_rstn_i) begin
      strb_q <= '0;
    end else if (beat_load_i) begin
      strb_q <= axi_wstrb_i;
    end
  end

  assign byte_o    = beat_q.lane[ls.lane_idx];
  assign byte_en_o = ls.step & strb_q[ls.lane_idx]; // masked lanes stay quiet.

endmodule

/* hdl/wr_burst_fsm.sv */
`timescale 1ns/1ps

module wr_burst_fsm (
  input  logic      mem_top,
  input  logic      axi_rstn_i,
  input  logic      axi_awvalid_i,
  input  logic      axi_wvalid_i,
  input  logic      axi_wlast_i,
  output logic      axi_awready_o,
  output logic      axi_wready_o,
  output logic      aw_load_o,
  output logic      beat_load_o,
  lane_step_if.ctl  ls
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DRAIN,
    ST_DONE
  } state_e;

  state_e state_q;
  state_e state_d;

  always_ff @(posedge mem_top) begin
    if (axi_rstn_i) begin
      state_q <= ST_DONE; // one quiet cycle before idle.
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (axi_awvalid_i) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (axi_wvalid_i) begin
          state_d = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        // leave after the top lane of the beat.
        if (ls.lane_last) begin
          state_d = ls.beat_last ? ST_DONE : ST_WAIT;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  assign axi_awready_o = (state_q == ST_IDLE);
  assign axi_wready_o  = (state_q == ST_WAIT);
  assign ls.step       = (state_q == ST_DRAIN);

  assign aw_load_o   = axi_awvalid_i & axi_awready_o;
  assign beat_load_o = axi_wvalid_i & axi_wready_o;

  // wlast must agree with the beat count of the latched awlen.
  a_wlast_match: assert property (
    @(posedge mem_top) disable iff (axi_rstn_i)
    beat_load_o |-> (axi_wlast_i == ls.beat_last)
  );

endmodule

/* mem_wr.f */
hdl/mem_wr_pkg.sv
hdl/lane_step_if.sv
hdl/wr_burst_fsm.sv
hdl/beat_lane_counter.sv
hdl/wdata_beat_buffer.sv
hdl/burst_addr_gen.sv
hdl/mem_wr_top.sv
sim/tb_mem_wr_top.sv

/* sim/tb_mem_wr_top.sv */
`timescale 1ns/1ps

module tb_mem_wr_top;
  import mem_wr_pkg::*;

  localparam int AXI_DW     = 32;
  localparam int AXI_AW     = 16;
  localparam int AXI_IW     = 4;
  localparam int SW         = AXI_DW / 8;
  localparam int NUM        = 7;
  localparam int RST_CYCLES = 8;

  typedef struct packed {
    logic [AXI_AW-1:0] addr;
    logic [LEN_W-1:0]  len;
    axi_burst_e        burst;
    logic              full_strb;
    logic [3:0]        hold;      // aw delay and gap between w beats.
  } entry_t;

  localparam entry_t STIM [NUM] = '{
    '{16'h0100, 4'd3,  BURST_INCR,  1'b1, 4'd0},
    '{16'h0208, 4'd2,  BURST_FIXED, 1'b1, 4'd0},
    '{16'h0335, 4'd3,  BURST_WRAP,  1'b1, 4'd1}, // unaligned, wraps to 0x330.
    '{16'h0400, 4'd7,  BURST_INCR,  1'b0, 4'd0},
    '{16'h0518, 4'd7,  BURST_WRAP,  1'b0, 4'd3},
    '{16'h0603, 4'd1,  BURST_INCR,  1'b0, 4'd2},
    '{16'h07f0, 4'd15, BURST_FIXED, 1'b0, 4'd1}
  };

  logic              clk;
  logic              rst;
  logic [AXI_IW-1:0] aw_id;
  logic [AXI_AW-1:0] aw_addr;
  logic [LEN_W-1:0]  aw_len;
  axi_burst_e        aw_burst;
  logic              aw_valid;
  logic              aw_ready;
  logic [AXI_IW-1:0] w_id;
  logic [AXI_DW-1:0] w_data;
  logic [SW-1:0]     w_strb;
  logic              w_last;
  logic              w_valid;
  logic              w_ready;
  logic              wen;
  logic [AXI_AW-1:0] waddr;
  logic [7:0]        wbyte;

  logic [31:0]         lfsr_q;
  logic [AXI_AW+7:0]   exp_q [$];  // {address, byte}.
  logic [AXI_AW+7:0]   mon_item;
  logic [AXI_DW-1:0]   beat_data [16];
  logic [SW-1:0]       beat_strb [16];
  int addr_err  = 0;
  int data_err  = 0;
  int extra_err = 0;
  int value_err = 0;
  int pend_err  = 0;
  int cycle_cnt = 0;
  int cycle_limit;

  mem_wr_top #(.AXI_DW(AXI_DW), .AXI_AW(AXI_AW), .AXI_IW(AXI_IW)) u_mem_wr_top (
    .mem_top(clk), .axi_rstn_i(rst),
    .axi_awid_i(aw_id), .axi_awaddr_i(aw_addr), .axi_awlen_i(aw_len),
    .axi_awburst_i(aw_burst), .axi_awvalid_i(aw_valid), .axi_awready_o(aw_ready),
    .axi_wid_i(w_id), .axi_wdata_i(w_data), .axi_wstrb_i(w_strb),
    .axi_wlast_i(w_last), .axi_wvalid_i(w_valid), .axi_wready_o(w_ready),
    .sys_wen_o(wen), .sys_addr_o(waddr), .sys_wdata_o(wbyte)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: no end of run after %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  // outputs only move on the rising edge.
  always @(negedge clk) begin
    if (!rst && wen) begin
      assert (exp_q.size() != 0) else begin
        extra_err++;
        $display("unexpected byte write to address %h with none pending", waddr);
      end
      if (exp_q.size() != 0) begin
        mon_item = exp_q.pop_front();
        assert (waddr == mon_item[AXI_AW+7:8]) else begin
          addr_err++;
          $display("Error: %0t ns, write address %h, expected %h",
                   $time, waddr, mon_item[AXI_AW+7:8]);
        end
        assert (wbyte == mon_item[7:0]) else begin
          data_err++;
          $display("Error: %0t ns, byte %h at %h, expected %h",
                   $time, wbyte, waddr, mon_item[7:0]);
        end
      end
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1.
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // axi address rule, wrap block holds the aligned start.
  function automatic logic [AXI_AW-1:0] expected_addr(input entry_t e, input int beat,
                                                      input int lane);
    int unsigned start;
    int unsigned block;
    int unsigned lower;
    int unsigned a;
    start = int'(e.addr) - int'(e.addr) % SW;
    block = (int'(e.len) + 1) * SW;
    case (e.burst)
      BURST_FIXED: a = start;
      BURST_WRAP: begin
        lower = start - start % block;
        a = lower + (start - lower + beat * SW) % block;
      end
      default: a = start + beat * SW;
    endcase
    a = a + lane;
    return a[AXI_AW-1:0];
  endfunction

  task automatic build_expected(input entry_t e);
    logic [31:0] r;
    for (int b = 0; b <= int'(e.len); b++) begin
      take_bits(AXI_DW, r);
      beat_data[b] = r;
      if (e.full_strb) begin
        beat_strb[b] = '1;
      end else begin
        take_bits(SW, r);
        beat_strb[b] = r[SW-1:0];
      end
      for (int l = 0; l < SW; l++) begin
        if (beat_strb[b][l]) begin
          exp_q.push_back({expected_addr(e, b, l), beat_data[b][l*8 +: 8]});
        end
      end
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic send_aw(input entry_t e, input logic [AXI_IW-1:0] id);
    logic hs;
    wait_cycles(int'(e.hold)); // w is presented first.
    aw_id    = id;
    aw_addr  = e.addr;
    aw_len   = e.len;
    aw_burst = e.burst;
    aw_valid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk);
      hs = aw_ready;
      @(posedge clk);
      #2;
    end
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input entry_t e, input logic [AXI_IW-1:0] id);
    logic hs;
    for (int b = 0; b <= int'(e.len); b++) begin
      if (b > 0) begin
        wait_cycles(int'(e.hold));
      end
      w_id    = id;
      w_data  = beat_data[b];
      w_strb  = beat_strb[b];
      w_last  = (b == int'(e.len));
      w_valid = 1'b1;
      hs = 1'b0;
      while (!hs) begin
        @(negedge clk);
        hs = w_ready;
        @(posedge clk);
        #2;
      end
      w_valid = 1'b0;
    end
  endtask

  initial begin
    rst      = 1'b1;
    aw_id    = '0;
    aw_addr  = '0;
    aw_len   = '0;
    aw_burst = BURST_INCR;
    aw_valid = 1'b0;
    w_id     = '0;
    w_data   = '0;
    w_strb   = '0;
    w_last   = 1'b0;
    w_valid  = 1'b0;
    lfsr_q   = 32'he55c;
    cycle_limit = RST_CYCLES + 64;
    for (int i = 0; i < NUM; i++) begin
      cycle_limit += (int'(STIM[i].len) + 1) * (SW + 2) + 4
                     + int'(STIM[i].hold) * (int'(STIM[i].len) + 2);
    end
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b0;
    @(negedge clk);
    assert (!aw_ready && !w_ready && !wen) else begin
      value_err++;
      $display("Error: %0t ns, handshake or write enable high right after reset", $time);
    end
    @(negedge clk);
    assert (aw_ready) else begin
      value_err++;
      $display("Error: %0t ns, awready still low one cycle after reset", $time);
    end
    @(posedge clk);
    #2;
    for (int i = 0; i < NUM; i++) begin
      build_expected(STIM[i]);
      fork
        send_aw(STIM[i], 4'(i));
        send_w(STIM[i], 4'(i));
      join
    end
    do @(negedge clk); while (!aw_ready); // last beat drained.
    assert (exp_q.size() == 0) else begin
      pend_err = exp_q.size();
      $display("%0d expected byte writes never appeared", pend_err);
    end
    $display("errors: address %0d, data %0d, unexpected %0d, value %0d, pending %0d",
             addr_err, data_err, extra_err, value_err, pend_err);
    if (addr_err + data_err + extra_err + value_err + pend_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
